// ==== design/cfg_reg_bank.sv ====
// --------------------
// configuration register bank
// filter, mapper and routing registers plus drop counters
// --------------------

`timescale 1ns/10ps
`include "spif_cfg.svh"

module cfg_reg_bank
(
  input  logic                tl_freerun_clk_int,
  input  logic                tl_reset_all_int,
  input  spif_pkg::cfg_wr_t   cfg_wr,
  input  spif_pkg::reg_addr_e cfg_rd_addr,
  input  logic                flt_drop,
  input  logic                rt_nomatch,
  input  logic                rt_waitdrop,
  output logic         [31:0] cfg_rd_data,
  output spif_pkg::flt_cfg_t  flt_cfg,
  output spif_pkg::map_cfg_t  map_cfg,
  output spif_pkg::rt_cfg_t   rt_cfg
);
  import spif_pkg::*;

  localparam int IDX_BITS = $clog2(`SPIF_NUM_RTREGS);

  // drop counters in the order filtered, no route, wait drop
  logic [2:0][31:0] cnt;
  logic [2:0]       cnt_inc;

  // table entry from an offset within a register group
  function automatic logic [IDX_BITS-1:0] ent_idx(input logic [`SPIF_ADR_BITS-1:0] ofs);
    return ofs[IDX_BITS-1:0];
  endfunction

  assign cnt_inc = {rt_waitdrop, rt_nomatch, flt_drop};

  // --------------------
  // register writes
  // --------------------
  always_ff @(posedge tl_freerun_clk_int or posedge tl_reset_all_int)
  begin
    if (tl_reset_all_int)
    begin
      flt_cfg <= '0;
      map_cfg <= '0;
      rt_cfg  <= '0;
    end
    else if (cfg_wr.en)
    begin
      case (cfg_wr.addr)
        FL_VAL0:   flt_cfg.val[0]  <= cfg_wr.data;
        FL_MSK0:   flt_cfg.msk[0]  <= cfg_wr.data;
        FL_VAL1:   flt_cfg.val[1]  <= cfg_wr.data;
        FL_MSK1:   flt_cfg.msk[1]  <= cfg_wr.data;
        MP_KEY:    map_cfg.key     <= cfg_wr.data;
        MP_FMSK0:  map_cfg.fmsk[0] <= cfg_wr.data;
        MP_FSFT0:  map_cfg.fsft[0] <= cfg_wr.data[`SPIF_SFT_BITS-1:0];
        MP_FMSK1:  map_cfg.fmsk[1] <= cfg_wr.data;
        MP_FSFT1:  map_cfg.fsft[1] <= cfg_wr.data[`SPIF_SFT_BITS-1:0];
        RT_KEY0, RT_KEY1, RT_KEY2, RT_KEY3:
          rt_cfg.ent[ent_idx(cfg_wr.addr - RT_KEY0)].key <= cfg_wr.data;
        RT_MSK0, RT_MSK1, RT_MSK2, RT_MSK3:
          rt_cfg.ent[ent_idx(cfg_wr.addr - RT_MSK0)].msk <= cfg_wr.data;
        RT_RTE0, RT_RTE1, RT_RTE2, RT_RTE3:
          rt_cfg.ent[ent_idx(cfg_wr.addr - RT_RTE0)].chan <= cfg_wr.data[0];
        DROP_WAIT: rt_cfg.drop_wait <= cfg_wr.data;
        // counters and unused addresses ignore writes
        default: ;
      endcase
    end
  end

  // saturating drop counters
  always_ff @(posedge tl_freerun_clk_int or posedge tl_reset_all_int)
  begin
    if (tl_reset_all_int)
      cnt <= '0;
    else
      for (int i = 0; i < 3; i++)
        if (cnt_inc[i] && (cnt[i] != '1))
          cnt[i] <= cnt[i] + 32'd1;
  end

  // --------------------
  // combinational read
  // --------------------
  always_comb
  begin
    case (cfg_rd_addr)
      FL_VAL0:      cfg_rd_data = flt_cfg.val[0];
      FL_MSK0:      cfg_rd_data = flt_cfg.msk[0];
      FL_VAL1:      cfg_rd_data = flt_cfg.val[1];
      FL_MSK1:      cfg_rd_data = flt_cfg.msk[1];
      MP_KEY:       cfg_rd_data = map_cfg.key;
      MP_FMSK0:     cfg_rd_data = map_cfg.fmsk[0];
      MP_FSFT0:     cfg_rd_data = {{(32-`SPIF_SFT_BITS){1'b0}}, map_cfg.fsft[0]};
      MP_FMSK1:     cfg_rd_data = map_cfg.fmsk[1];
      MP_FSFT1:     cfg_rd_data = {{(32-`SPIF_SFT_BITS){1'b0}}, map_cfg.fsft[1]};
      RT_KEY0, RT_KEY1, RT_KEY2, RT_KEY3:
        cfg_rd_data = rt_cfg.ent[ent_idx(cfg_rd_addr - RT_KEY0)].key;
      RT_MSK0, RT_MSK1, RT_MSK2, RT_MSK3:
        cfg_rd_data = rt_cfg.ent[ent_idx(cfg_rd_addr - RT_MSK0)].msk;
      RT_RTE0, RT_RTE1, RT_RTE2, RT_RTE3:
        cfg_rd_data = {31'b0, rt_cfg.ent[ent_idx(cfg_rd_addr - RT_RTE0)].chan};
      DROP_WAIT:    cfg_rd_data = rt_cfg.drop_wait;
      CNT_FILT:     cfg_rd_data = cnt[0];
      CNT_NOROUTE:  cfg_rd_data = cnt[1];
      CNT_WAITDROP: cfg_rd_data = cnt[2];
      // unused addresses read as zero
      default:      cfg_rd_data = '0;
    endcase
  end

  // counter address writes leave every register as it was
  a_cnt_ro: assert property (@(posedge tl_freerun_clk_int) disable iff (tl_reset_all_int)
    (cfg_wr.en && (cfg_wr.addr inside {CNT_FILT, CNT_NOROUTE, CNT_WAITDROP})) |=>
    ($stable(flt_cfg) && $stable(map_cfg) && $stable(rt_cfg)));

endmodule

// ==== design/evt_filter.sv ====
// --------------------
// event filter stage
// four-phase event input, drops events hit by an enabled filter
// --------------------

`timescale 1ns/10ps
`include "spif_cfg.svh"

module evt_filter
(
  input  logic               tl_freerun_clk_int,
  input  logic               tl_reset_all_int,
  input  logic               evt_req,
  input  spif_pkg::evt_t     evt_data,
  input  spif_pkg::flt_cfg_t flt_cfg,
  input  logic               stall_in,
  output logic               evt_ack,
  output spif_pkg::pkt_t     flt_pkt,
  output logic               flt_drop
);
  import spif_pkg::*;

  logic [`SPIF_NUM_FLREGS-1:0] flt_hit;
  logic                        load_ok;
  logic                        take;

  // a filter with a zero mask is off
  always_comb
  begin
    for (int i = 0; i < `SPIF_NUM_FLREGS; i++)
      flt_hit[i] = (|flt_cfg.msk[i]) &&
                   ((evt_data & flt_cfg.msk[i]) == flt_cfg.val[i]);
  end

  // output register free or about to be emptied
  assign load_ok = !flt_pkt.vld || !stall_in;

  // new event only once the previous ack has dropped
  assign take = evt_req && !evt_ack && load_ok;

  // --------------------
  // handshake and output register
  // --------------------
  always_ff @(posedge tl_freerun_clk_int or posedge tl_reset_all_int)
  begin
    if (tl_reset_all_int)
    begin
      evt_ack  <= 1'b0;
      flt_pkt  <= '0;
      flt_drop <= 1'b0;
    end
    else
    begin
      flt_drop <= take && (|flt_hit);

      // ack up on capture, down after req falls
      if (take)
        evt_ack <= 1'b1;
      else if (evt_ack && !evt_req)
        evt_ack <= 1'b0;

      if (take && !(|flt_hit))
        flt_pkt <= '{vld: 1'b1, key: evt_data};
      else if (load_ok)
        flt_pkt.vld <= 1'b0;
    end
  end

  // no ack without a pending request
  a_ack_after_req: assert property (@(posedge tl_freerun_clk_int)
    disable iff (tl_reset_all_int)
    (!evt_req && !evt_ack) |=> !evt_ack);

endmodule

// ==== design/evt_mapper.sv ====
// --------------------
// event mapper stage
// builds the packet key from base key and two event fields
// --------------------

`timescale 1ns/10ps
`include "spif_cfg.svh"

module evt_mapper
(
  input  logic               tl_freerun_clk_int,
  input  logic               tl_reset_all_int,
  input  spif_pkg::pkt_t     flt_pkt,
  input  spif_pkg::map_cfg_t map_cfg,
  input  logic               stall_in,
  output logic               stall_out,
  output spif_pkg::pkt_t     map_pkt
);
  import spif_pkg::*;

  key_t mapped_key;
  evt_t evt;
  logic load;

  // event travels in the key field of the filter item
  assign evt = flt_pkt.key;

  // --------------------
  // key assembly
  // --------------------
  always_comb
  begin
    mapped_key = map_cfg.key;
    // each field: mask, then shift down into place
    for (int f = 0; f < `SPIF_NUM_FIELDS; f++)
      mapped_key = mapped_key | ((evt & map_cfg.fmsk[f]) >> map_cfg.fsft[f]);
  end

  // holding an item the router will not take
  assign stall_out = map_pkt.vld && stall_in;

  assign load = !map_pkt.vld || !stall_in;

  // one cycle through when the router keeps up
  always_ff @(posedge tl_freerun_clk_int or posedge tl_reset_all_int)
  begin
    if (tl_reset_all_int)
      map_pkt <= '0;
    else if (load)
    begin
      map_pkt.vld <= flt_pkt.vld;
      // key follows only with a real item
      if (flt_pkt.vld)
        map_pkt.key <= mapped_key;
    end
  end

endmodule

// ==== design/evt_to_spinn_top.sv ====
// --------------------
// event sensor to spinnaker bridge
// filter, mapper and router in series with the register bank
// --------------------

`timescale 1ns/10ps
`include "spif_cfg.svh"

module evt_to_spinn_top
(
  input  logic                                 tl_freerun_clk_int,
  input  logic                                 tl_reset_all_int,
  input  logic                                 evt_req,
  input  spif_pkg::evt_t                       evt_data,
  input  spif_pkg::cfg_wr_t                    cfg_wr,
  input  spif_pkg::reg_addr_e                  cfg_rd_addr,
  input  logic           [`SPIF_NUM_CHANS-1:0] ch_ack,
  output logic                                 evt_ack,
  output logic                          [31:0] cfg_rd_data,
  output logic           [`SPIF_NUM_CHANS-1:0] ch_req,
  output spif_pkg::key_t [`SPIF_NUM_CHANS-1:0] ch_data
);
  import spif_pkg::*;

  // configuration from the register bank
  flt_cfg_t flt_cfg;
  map_cfg_t map_cfg;
  rt_cfg_t  rt_cfg;

  // pipeline items and stalls
  pkt_t flt_pkt;
  pkt_t map_pkt;
  logic map_stall;
  logic rt_stall;

  // drop pulses to the counters
  logic flt_drop;
  logic rt_nomatch;
  logic rt_waitdrop;

  // --------------------
  // register bank
  // --------------------
  cfg_reg_bank rb (
      .tl_freerun_clk_int (tl_freerun_clk_int)
    , .tl_reset_all_int   (tl_reset_all_int)
    , .cfg_wr             (cfg_wr)
    , .cfg_rd_addr        (cfg_rd_addr)
    , .flt_drop           (flt_drop)
    , .rt_nomatch         (rt_nomatch)
    , .rt_waitdrop        (rt_waitdrop)
    , .cfg_rd_data        (cfg_rd_data)
    , .flt_cfg            (flt_cfg)
    , .map_cfg            (map_cfg)
    , .rt_cfg             (rt_cfg)
    );

  // --------------------
  // event pipeline
  // --------------------
  evt_filter fl (
      .tl_freerun_clk_int (tl_freerun_clk_int)
    , .tl_reset_all_int   (tl_reset_all_int)
    , .evt_req            (evt_req)
    , .evt_data           (evt_data)
    , .flt_cfg            (flt_cfg)
    , .stall_in           (map_stall)
    , .evt_ack            (evt_ack)
    , .flt_pkt            (flt_pkt)
    , .flt_drop           (flt_drop)
    );

  evt_mapper mp (
      .tl_freerun_clk_int (tl_freerun_clk_int)
    , .tl_reset_all_int   (tl_reset_all_int)
    , .flt_pkt            (flt_pkt)
    , .map_cfg            (map_cfg)
    , .stall_in           (rt_stall)
    , .stall_out          (map_stall)
    , .map_pkt            (map_pkt)
    );

  // router owns the channel ports
  pkt_router pr (
      .tl_freerun_clk_int (tl_freerun_clk_int)
    , .tl_reset_all_int   (tl_reset_all_int)
    , .map_pkt            (map_pkt)
    , .rt_cfg             (rt_cfg)
    , .ch_ack             (ch_ack)
    , .stall_out          (rt_stall)
    , .ch_req             (ch_req)
    , .ch_data            (ch_data)
    , .rt_nomatch         (rt_nomatch)
    , .rt_waitdrop        (rt_waitdrop)
    );

endmodule

// ==== design/pkt_router.sv ====
// --------------------
// packet router stage
// table lookup, per-channel four-phase outputs, drop on long wait
// --------------------

`timescale 1ns/10ps
`include "spif_cfg.svh"

module pkt_router
(
  input  logic                                 tl_freerun_clk_int,
  input  logic                                 tl_reset_all_int,
  input  spif_pkg::pkt_t                       map_pkt,
  input  spif_pkg::rt_cfg_t                    rt_cfg,
  input  logic           [`SPIF_NUM_CHANS-1:0] ch_ack,
  output logic                                 stall_out,
  output logic           [`SPIF_NUM_CHANS-1:0] ch_req,
  output spif_pkg::key_t [`SPIF_NUM_CHANS-1:0] ch_data,
  output logic                                 rt_nomatch,
  output logic                                 rt_waitdrop
);
  import spif_pkg::*;

  out_state_e                 st       [`SPIF_NUM_CHANS];
  logic [31:0]                wait_cnt [`SPIF_NUM_CHANS];
  logic                       hit;
  logic                       tgt;
  logic                       busy;
  logic                       expire;
  logic [`SPIF_NUM_CHANS-1:0] sel;

  // --------------------
  // route lookup
  // --------------------
  // walk downwards so the lowest matching entry wins
  always_comb
  begin
    hit = 1'b0;
    tgt = 1'b0;
    for (int i = `SPIF_NUM_RTREGS - 1; i >= 0; i--)
      if ((|rt_cfg.ent[i].msk) &&
          ((map_pkt.key & rt_cfg.ent[i].msk) == rt_cfg.ent[i].key))
      begin
        hit = 1'b1;
        tgt = rt_cfg.ent[i].chan;
      end
  end

  // channel the head packet wants
  always_comb
  begin
    sel = '0;
    if (map_pkt.vld && hit)
      sel[tgt] = 1'b1;
  end

  assign busy = (st[tgt] != OUT_IDLE);

  // drop wait of zero means wait forever
  assign expire = (rt_cfg.drop_wait != '0) &&
                  (wait_cnt[tgt] >= (rt_cfg.drop_wait - 32'd1));

  assign stall_out = map_pkt.vld && hit && busy && !expire;

  // one-cycle drop pulses for the counters
  always_ff @(posedge tl_freerun_clk_int or posedge tl_reset_all_int)
  begin
    if (tl_reset_all_int)
    begin
      rt_nomatch  <= 1'b0;
      rt_waitdrop <= 1'b0;
    end
    else
    begin
      rt_nomatch  <= map_pkt.vld && !hit;
      rt_waitdrop <= map_pkt.vld && hit && busy && expire;
    end
  end

  // --------------------
  // per-channel output FSM
  // --------------------
  always_ff @(posedge tl_freerun_clk_int or posedge tl_reset_all_int)
  begin
    if (tl_reset_all_int)
    begin
      ch_req <= '0;
      for (int c = 0; c < `SPIF_NUM_CHANS; c++)
      begin
        st[c]       <= OUT_IDLE;
        wait_cnt[c] <= '0;
      end
    end
    else
    begin
      for (int c = 0; c < `SPIF_NUM_CHANS; c++)
      begin
        // consecutive cycles the head waits on this channel
        if (sel[c] && busy && !expire && (rt_cfg.drop_wait != '0))
          wait_cnt[c] <= wait_cnt[c] + 32'd1;
        else if (!(sel[c] && busy))
          wait_cnt[c] <= '0;
        else if (expire)
          wait_cnt[c] <= '0;

        case (st[c])
          OUT_IDLE:
            if (sel[c])
              st[c] <= OUT_REQ;
          // req goes up the cycle after the holder loads
          OUT_REQ:
            if (ch_req[c] && ch_ack[c])
            begin
              ch_req[c] <= 1'b0;
              st[c]     <= OUT_RELEASE;
            end
            else
              ch_req[c] <= 1'b1;
          OUT_RELEASE:
            if (!ch_ack[c])
              st[c] <= OUT_IDLE;
          default:
            st[c] <= OUT_IDLE;
        endcase
      end
    end
  end

  // output holders, loaded only from idle
  always_ff @(posedge tl_freerun_clk_int)
  begin
    for (int c = 0; c < `SPIF_NUM_CHANS; c++)
      if (sel[c] && (st[c] == OUT_IDLE))
        ch_data[c] <= map_pkt.key;
  end

  // four-phase rules seen at each channel port
  for (genvar c = 0; c < `SPIF_NUM_CHANS; c++)
  begin : g_chk
    a_req_hold: assert property (@(posedge tl_freerun_clk_int)
      disable iff (tl_reset_all_int)
      $fell(ch_req[c]) |-> $past(ch_ack[c]));

    a_data_stable: assert property (@(posedge tl_freerun_clk_int)
      disable iff (tl_reset_all_int)
      ch_req[c] |=> $stable(ch_data[c]));
  end

endmodule

// ==== design/spif_cfg.svh ====
// --------------------
// event to spinnaker bridge
// sizing macros for widths, tables and registers
// --------------------

`ifndef SPIF_CFG_SVH
`define SPIF_CFG_SVH

// data path widths
`define SPIF_EVT_BITS   32
`define SPIF_KEY_BITS   32

// table sizes
`define SPIF_NUM_FLREGS 2
`define SPIF_NUM_FIELDS 2
`define SPIF_NUM_RTREGS 4
`define SPIF_NUM_CHANS  2

// field shift and register address widths
`define SPIF_SFT_BITS   5
`define SPIF_ADR_BITS   5

// registers in use, addresses above are unused
`define SPIF_NUM_REGS   25

`endif

// ==== design/spif_pkg.sv ====
// --------------------
// event to spinnaker bridge
// shared types for the event pipeline and register bank
// --------------------

`include "spif_cfg.svh"

package spif_pkg;

  typedef logic [`SPIF_EVT_BITS-1:0] evt_t;
  typedef logic [`SPIF_KEY_BITS-1:0] key_t;

  // register map, counters sit at the top
  typedef enum logic [`SPIF_ADR_BITS-1:0] {
    FL_VAL0, FL_MSK0, FL_VAL1, FL_MSK1,
    MP_KEY, MP_FMSK0, MP_FSFT0, MP_FMSK1, MP_FSFT1,
    RT_KEY0, RT_KEY1, RT_KEY2, RT_KEY3,
    RT_MSK0, RT_MSK1, RT_MSK2, RT_MSK3,
    RT_RTE0, RT_RTE1, RT_RTE2, RT_RTE3,
    DROP_WAIT,
    CNT_FILT, CNT_NOROUTE, CNT_WAITDROP
  } reg_addr_e;

  // four-phase output cycle per channel
  typedef enum logic [1:0] {
    OUT_IDLE,
    OUT_REQ,
    OUT_RELEASE
  } out_state_e;

  // item between stages
  // the filter carries the raw event in key
  typedef struct packed {
    logic vld;
    key_t key;
  } pkt_t;

  typedef struct packed {
    logic        en;
    reg_addr_e   addr;
    logic [31:0] data;
  } cfg_wr_t;

  typedef struct packed {
    evt_t [`SPIF_NUM_FLREGS-1:0] val;
    evt_t [`SPIF_NUM_FLREGS-1:0] msk;
  } flt_cfg_t;

  typedef struct packed {
    key_t                                        key;
    evt_t [`SPIF_NUM_FIELDS-1:0]                 fmsk;
    logic [`SPIF_NUM_FIELDS-1:0][`SPIF_SFT_BITS-1:0] fsft;
  } map_cfg_t;

  typedef struct packed {
    key_t key;
    key_t msk;
    logic chan;
  } rt_ent_t;

  typedef struct packed {
    rt_ent_t [`SPIF_NUM_RTREGS-1:0] ent;
    logic    [31:0]                 drop_wait;
  } rt_cfg_t;

endpackage

// ==== flist.f ====
+incdir+design
design/spif_pkg.sv
design/cfg_reg_bank.sv
design/evt_filter.sv
design/evt_mapper.sv
design/pkt_router.sv
design/evt_to_spinn_top.sv
sim/tb_evt_to_spinn.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with verilator, run it, judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -j 0 -f flist.f --top-module tb_evt_to_spinn \
  -o tb_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "Test failed" sim.log && { tail -n 20 sim.log; exit 1; }
grep -q "Test passed" sim.log || { tail -n 20 sim.log; echo "no result in sim.log"; exit 1; }
echo "simulation passed"

// ==== sim/tb_evt_to_spinn.sv ====
// --------------------
// testbench for the event to spinnaker bridge
// random events through a reference model, four-phase sinks,
// protocol assertions and register checks
// --------------------

`timescale 1ns/10ps
`include "spif_cfg.svh"

module tb_evt_to_spinn;
  import spif_pkg::*;

  localparam int WAIT_LIMIT = 200;

  logic                       tl_freerun_clk_int = 1'b0;
  logic                       tl_reset_all_int;
  logic                       evt_req;
  evt_t                       evt_data;
  cfg_wr_t                    cfg_wr;
  reg_addr_e                  cfg_rd_addr;
  logic [`SPIF_NUM_CHANS-1:0] ch_ack;
  logic                       evt_ack;
  logic [31:0]                cfg_rd_data;
  logic [`SPIF_NUM_CHANS-1:0] ch_req;
  key_t [`SPIF_NUM_CHANS-1:0] ch_data;

  // model state
  logic [31:0]                shadow [32];
  key_t                       exp_q [`SPIF_NUM_CHANS][$];
  logic [31:0]                exp_filt;
  logic [31:0]                exp_noroute;
  logic [31:0]                exp_waitdrop;
  logic [`SPIF_NUM_CHANS-1:0] ack_hold;
  logic [31:0]                rng;

  always #2 tl_freerun_clk_int = ~tl_freerun_clk_int;

  evt_to_spinn_top UUT (
      .tl_freerun_clk_int (tl_freerun_clk_int)
    , .tl_reset_all_int   (tl_reset_all_int)
    , .evt_req            (evt_req)
    , .evt_data           (evt_data)
    , .cfg_wr             (cfg_wr)
    , .cfg_rd_addr        (cfg_rd_addr)
    , .ch_ack             (ch_ack)
    , .evt_ack            (evt_ack)
    , .cfg_rd_data        (cfg_rd_data)
    , .ch_req             (ch_req)
    , .ch_data            (ch_data)
    );

  // --------------------
  // failure reporting
  // --------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string sig, input logic [31:0] exp,
                                input logic [31:0] got);
    abort_run($sformatf("ERROR at %0t: %s expected %h, got %h", $time, sig, exp, got));
  endtask

  // --------------------
  // reference model
  // --------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // readable bits per register
  function automatic logic [31:0] reg_mask(input reg_addr_e a);
    case (a)
      MP_FSFT0, MP_FSFT1:                 return (32'd1 << `SPIF_SFT_BITS) - 32'd1;
      RT_RTE0, RT_RTE1, RT_RTE2, RT_RTE3: return 32'd1;
      default:                            return 32'hFFFF_FFFF;
    endcase
  endfunction

  // a zero mask switches a filter off
  function automatic logic filter_hit(input evt_t ev);
    logic hit;
    hit = 1'b0;
    if ((shadow[FL_MSK0] != '0) && ((ev & shadow[FL_MSK0]) == shadow[FL_VAL0]))
      hit = 1'b1;
    if ((shadow[FL_MSK1] != '0) && ((ev & shadow[FL_MSK1]) == shadow[FL_VAL1]))
      hit = 1'b1;
    return hit;
  endfunction

  function automatic key_t map_key(input evt_t ev);
    return shadow[MP_KEY] | ((ev & shadow[MP_FMSK0]) >> shadow[MP_FSFT0][4:0])
                          | ((ev & shadow[MP_FMSK1]) >> shadow[MP_FSFT1][4:0]);
  endfunction

  // channel of the lowest matching entry or -1 for no route
  function automatic int route_of(input key_t key);
    int         ch;
    logic [4:0] k_adr;
    logic [4:0] m_adr;
    logic [4:0] r_adr;
    ch = -1;
    for (int i = 0; i < `SPIF_NUM_RTREGS; i++)
    begin
      k_adr = 5'(int'(RT_KEY0) + i);
      m_adr = 5'(int'(RT_MSK0) + i);
      r_adr = 5'(int'(RT_RTE0) + i);
      if ((ch < 0) && (shadow[m_adr] != '0) && ((key & shadow[m_adr]) == shadow[k_adr]))
        ch = int'(shadow[r_adr][0]);
    end
    return ch;
  endfunction

  // expected fate of one event
  task automatic model_event(input evt_t ev);
    key_t key;
    int   ch;
    if (filter_hit(ev))
      exp_filt = exp_filt + 32'd1;
    else
    begin
      key = map_key(ev);
      ch  = route_of(key);
      if (ch < 0)
        exp_noroute = exp_noroute + 32'd1;
      // blocked channel already holds a packet, so this one times out
      else if (ack_hold[1'(ch)] && (exp_q[1'(ch)].size() > 0) && (shadow[DROP_WAIT] != '0))
        exp_waitdrop = exp_waitdrop + 32'd1;
      else
        exp_q[1'(ch)].push_back(key);
    end
  endtask

  // --------------------
  // bus tasks
  // --------------------
  task automatic write_reg(input reg_addr_e a, input logic [31:0] d);
    cfg_wr = '{en: 1'b1, addr: a, data: d};
    if (a <= DROP_WAIT)
      shadow[a] = d & reg_mask(a);
    @(posedge tl_freerun_clk_int);
    #1;
    cfg_wr.en = 1'b0;
  endtask

  task automatic read_check(input reg_addr_e a, input logic [31:0] exp);
    cfg_rd_addr = a;
    #1;
    assert (cfg_rd_data == exp)
    else value_mismatch($sformatf("cfg_rd_data[%0d]", a), exp, cfg_rd_data);
    @(posedge tl_freerun_clk_int);
    #1;
  endtask

  // poll a counter until it reaches the model count
  task automatic wait_counter(input reg_addr_e a, input logic [31:0] exp);
    int n;
    n = 0;
    cfg_rd_addr = a;
    #1;
    while (cfg_rd_data != exp)
    begin
      @(posedge tl_freerun_clk_int);
      #2;
      n++;
      if (n > WAIT_LIMIT)
        value_mismatch(a.name(), exp, cfg_rd_data);
    end
    @(posedge tl_freerun_clk_int);
    #1;
  endtask

  task automatic readback_all();
    for (int a = 0; a <= int'(DROP_WAIT); a++)
      read_check(reg_addr_e'(5'(a)), shadow[5'(a)]);
    // unused addresses
    for (int a = `SPIF_NUM_REGS; a < 32; a++)
      read_check(reg_addr_e'(5'(a)), 32'h0);
  endtask

  // four-phase source side
  task automatic send_event(input evt_t ev);
    int n;
    model_event(ev);
    evt_data = ev;
    evt_req  = 1'b1;
    n = 0;
    while (!evt_ack)
    begin
      @(posedge tl_freerun_clk_int);
      #1;
      n++;
      if (n > WAIT_LIMIT)
        abort_run($sformatf("timeout at %0t waiting for evt_ack to rise", $time));
    end
    evt_req = 1'b0;
    n = 0;
    while (evt_ack)
    begin
      @(posedge tl_freerun_clk_int);
      #1;
      n++;
      if (n > WAIT_LIMIT)
        abort_run($sformatf("timeout at %0t waiting for evt_ack to fall", $time));
    end
  endtask

  task automatic wait_drain(input logic c);
    int n;
    n = 0;
    while (exp_q[c].size() != 0)
    begin
      @(posedge tl_freerun_clk_int);
      #1;
      n++;
      if (n > WAIT_LIMIT)
        abort_run($sformatf("timeout, channel %0d still owes %0d packets",
                            c, exp_q[c].size()));
    end
  endtask

  // --------------------
  // channel sinks
  // --------------------
  task automatic sink_step(input logic c);
    key_t exp_key;
    if (ch_req[c] && !ch_ack[c] && !ack_hold[c])
    begin
      if (exp_q[c].size() == 0)
        abort_run($sformatf("channel %0d sent key %h that the model did not expect",
                            c, ch_data[c]));
      else
      begin
        exp_key = exp_q[c].pop_front();
        assert (ch_data[c] == exp_key)
        else value_mismatch($sformatf("ch_data[%0d]", c), exp_key, ch_data[c]);
      end
      ch_ack[c] = 1'b1;
    end
    else if (!ch_req[c] && ch_ack[c])
      ch_ack[c] = 1'b0;
  endtask

  initial
  begin
    ch_ack = '0;
    forever
    begin
      @(posedge tl_freerun_clk_int);
      #1;
      if (!tl_reset_all_int)
      begin
        sink_step(1'b0);
        sink_step(1'b1);
      end
    end
  end

  // --------------------
  // port protocol checks
  // --------------------
  a_reset_low: assert property (@(posedge tl_freerun_clk_int)
    tl_reset_all_int |-> (!evt_ack && (ch_req == '0)))
    else abort_run("evt_ack or ch_req high during reset");

  a_ack_rise: assert property (@(posedge tl_freerun_clk_int) disable iff (tl_reset_all_int)
    $rose(evt_ack) |-> $past(evt_req))
    else abort_run("evt_ack rose without a pending evt_req");

  a_ack_fall: assert property (@(posedge tl_freerun_clk_int) disable iff (tl_reset_all_int)
    $fell(evt_ack) |-> !$past(evt_req))
    else abort_run("evt_ack fell while evt_req was still high");

  for (genvar c = 0; c < `SPIF_NUM_CHANS; c++)
  begin : g_port_chk
    a_req_fall: assert property (@(posedge tl_freerun_clk_int)
      disable iff (tl_reset_all_int)
      $fell(ch_req[c]) |-> $past(ch_ack[c]))
      else abort_run($sformatf("ch_req[%0d] fell before ch_ack rose", c));

    a_data_hold: assert property (@(posedge tl_freerun_clk_int)
      disable iff (tl_reset_all_int)
      (ch_req[c] && $past(ch_req[c])) |-> $stable(ch_data[c]))
      else abort_run($sformatf("ch_data[%0d] changed while ch_req was high", c));
  end

  // --------------------
  // main sequence
  // --------------------
  initial
  begin
    tl_reset_all_int = 1'b1;
    evt_req          = 1'b0;
    evt_data         = '0;
    cfg_wr           = '0;
    cfg_rd_addr      = FL_VAL0;
    ack_hold         = '0;
    exp_filt         = '0;
    exp_noroute      = '0;
    exp_waitdrop     = '0;
    rng              = 32'd9412;
    for (int a = 0; a < 32; a++)
      shadow[5'(a)] = '0;

    repeat (16) @(posedge tl_freerun_clk_int);
    #1;
    tl_reset_all_int = 1'b0;
    assert (!evt_ack && (ch_req == '0))
    else abort_run("evt_ack or ch_req high after reset");

    // everything zero out of reset
    readback_all();
    read_check(CNT_FILT, 32'h0);
    read_check(CNT_NOROUTE, 32'h0);
    read_check(CNT_WAITDROP, 32'h0);

    // per-address fill and read back
    for (int a = 0; a <= int'(DROP_WAIT); a++)
      write_reg(reg_addr_e'(5'(a)), 32'h5A00_0000 ^ (32'(a) * 32'h0001_0203));
    readback_all();

    // filter 0 drops top nibble A while filter 1 stays off
    write_reg(FL_VAL0, 32'hA000_0000);
    write_reg(FL_MSK0, 32'hF000_0000);
    write_reg(FL_VAL1, 32'h0000_0000);
    write_reg(FL_MSK1, 32'h0000_0000);
    // key = base | ev[7:0] | ev[23:16] into bits 15:8
    write_reg(MP_KEY, 32'h1200_0000);
    write_reg(MP_FMSK0, 32'h0000_00FF);
    write_reg(MP_FSFT0, 32'd0);
    write_reg(MP_FMSK1, 32'h00FF_0000);
    write_reg(MP_FSFT1, 32'd8);
    // entry 0 sends low bits 00 to ch0 and entry 1 sends odd keys to ch1
    write_reg(RT_KEY0, 32'h0000_0000);
    write_reg(RT_MSK0, 32'h0000_0003);
    write_reg(RT_RTE0, 32'd0);
    write_reg(RT_KEY1, 32'h0000_0001);
    write_reg(RT_MSK1, 32'h0000_0001);
    write_reg(RT_RTE1, 32'd1);
    // entry 2 is off and would catch everything
    write_reg(RT_KEY2, 32'h0000_0000);
    write_reg(RT_MSK2, 32'h0000_0000);
    write_reg(RT_RTE2, 32'd1);
    // entry 3 overlaps entry 0 and loses on priority
    write_reg(RT_KEY3, 32'h0000_0100);
    write_reg(RT_MSK3, 32'h0000_0300);
    write_reg(RT_RTE3, 32'd1);
    write_reg(DROP_WAIT, 32'd0);
    readback_all();

    // random traffic with high LCG bits folded into the routing bits
    for (int i = 0; i < 200; i++)
    begin
      rng = lcg_next(rng);
      send_event({rng[15:0], rng[31:16]});
    end
    wait_drain(1'b0);
    wait_drain(1'b1);
    wait_counter(CNT_FILT, exp_filt);
    wait_counter(CNT_NOROUTE, exp_noroute);
    wait_counter(CNT_WAITDROP, exp_waitdrop);

    // counters and unused addresses ignore writes
    write_reg(CNT_FILT, 32'hFFFF_0000);
    write_reg(reg_addr_e'(5'd30), 32'h0BAD_F00D);
    read_check(CNT_FILT, exp_filt);
    read_check(reg_addr_e'(5'd30), 32'h0);

    // --------------------
    // drop wait with channel 1 blocked
    // --------------------
    write_reg(DROP_WAIT, 32'd8);
    ack_hold[1] = 1'b1;
    send_event(32'h0000_0011);
    for (int k = 0; k < 4; k++)
      send_event(32'h0000_0003 + 32'(k) * 32'h10);
    // channel 0 behind the dropped packets
    for (int k = 0; k < 4; k++)
      send_event(32'h0000_0004 + 32'(k) * 32'h10);
    wait_drain(1'b0);
    wait_counter(CNT_WAITDROP, exp_waitdrop);
    ack_hold[1] = 1'b0;
    wait_drain(1'b1);
    read_check(CNT_FILT, exp_filt);
    read_check(CNT_NOROUTE, exp_noroute);
    read_check(CNT_WAITDROP, exp_waitdrop);

    $display("Test passed");
    $finish;
  end

endmodule
